//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // base integer ISA widths
  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;
  localparam int opcode_w  = 7;
  localparam int funct3_w  = 3;
  localparam int funct7_w  = 7;
  localparam int shamt_w   = 5;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [funct3_w-1:0]  funct3_t;
  typedef logic [funct7_w-1:0]  funct7_t;

  // major opcodes kept by the core, anything else decodes as illegal
  typedef enum logic [opcode_w-1:0] {
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_branch  = 7'b1100011,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_system  = 7'b1110011
  } opcode_e;

  // alu funct3, shared by reg-imm and reg-reg
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  localparam funct3_t f3_jalr = 3'b000;

  // f7_alt selects sub and sra
  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;

  // the only system encoding kept
  localparam word_t insn_ecall = 32'h0000_0073;

endpackage

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;
  import rv_isa_pkg::*;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    br_never,
    br_always,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } branch_cond_e;

  // decoder output, consumed by execute and commit
  typedef struct packed {
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;
    alu_op_e      alu_op;
    logic         op_a_is_pc;
    logic         op_b_is_imm;
    branch_cond_e branch_cond;
    logic         target_from_rs1;
    logic         link;
    logic         writes_rd;
    logic         is_halt;
    logic         illegal;
  } decoded_t;

  typedef struct packed {
    word_t rd_data;
    word_t next_pc;
    logic  taken;
  } exec_t;

  // one record per committed instruction
  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    reg_idx_t rd;
    logic     we;
    word_t    rd_data;
    logic     illegal;
    logic     halt;
  } retire_t;

endpackage

`default_nettype wire

//--- logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_isa_pkg::*; import core_pkg::*; (
  input  wire word_t insn,
  output decoded_t   dec
);

  opcode_e opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;

  assign opcode = opcode_e'(insn[opcode_w-1:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  function automatic alu_op_e alu_from_funct3(funct3_t f3, logic alt);
    alu_op_e op;
    case (f3)
      f3_add_sub: op = alt ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      default:    op = alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    dec                 = '0;
    dec.rs1             = insn[19:15];
    dec.rs2             = insn[24:20];
    dec.rd              = insn[11:7];
    dec.imm             = imm_i;
    dec.alu_op          = alu_add;
    dec.branch_cond     = br_never;

    case (opcode)
      op_lui: begin
        dec.imm         = imm_u;
        dec.alu_op      = alu_pass_b;
        dec.op_b_is_imm = 1'b1;
        dec.writes_rd   = 1'b1;
      end
      op_auipc: begin
        dec.imm         = imm_u;
        dec.op_a_is_pc  = 1'b1;
        dec.op_b_is_imm = 1'b1;
        dec.writes_rd   = 1'b1;
      end
      op_jal: begin
        dec.imm         = imm_j;
        dec.branch_cond = br_always;
        dec.link        = 1'b1;
        dec.writes_rd   = 1'b1;
      end
      op_jalr: begin
        dec.branch_cond     = br_always;
        dec.target_from_rs1 = 1'b1;
        dec.link            = 1'b1;
        dec.writes_rd       = 1'b1;
        dec.illegal         = (funct3 != f3_jalr);
      end
      op_branch: begin
        dec.imm = imm_b;
        case (funct3)
          f3_beq:  dec.branch_cond = br_eq;
          f3_bne:  dec.branch_cond = br_ne;
          f3_blt:  dec.branch_cond = br_lt;
          f3_bge:  dec.branch_cond = br_ge;
          f3_bltu: dec.branch_cond = br_ltu;
          f3_bgeu: dec.branch_cond = br_geu;
          default: dec.illegal     = 1'b1;
        endcase
      end
      op_reg_imm: begin
        // bit 30 is immediate data except on the right shift
        dec.alu_op      = alu_from_funct3(funct3, funct3 == f3_srl_sra && funct7 == f7_alt);
        dec.op_b_is_imm = 1'b1;
        dec.writes_rd   = 1'b1;
        if (funct3 == f3_sll && funct7 != f7_base) begin
          dec.illegal = 1'b1;
        end
        if (funct3 == f3_srl_sra && funct7 != f7_base && funct7 != f7_alt) begin
          dec.illegal = 1'b1;
        end
      end
      op_reg_reg: begin
        dec.alu_op    = alu_from_funct3(funct3, funct7 == f7_alt);
        dec.writes_rd = 1'b1;
        if (funct7 == f7_alt) begin
          dec.illegal = (funct3 != f3_add_sub) && (funct3 != f3_srl_sra);
        end else begin
          // M extension and other funct7 values land here
          dec.illegal = (funct7 != f7_base);
        end
      end
      op_system: begin
        if (insn == insn_ecall) begin
          dec.is_halt = 1'b1;
        end else begin
          dec.illegal = 1'b1;
        end
      end
      default: dec.illegal = 1'b1;
    endcase

    // illegal retires as a plain fall-through
    if (dec.illegal) begin
      dec.writes_rd   = 1'b0;
      dec.branch_cond = br_never;
    end
  end

  always_comb begin
    assert (!(dec.illegal && dec.is_halt))
      else $error("decode flags insn %h both illegal and halt", insn);
  end

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_isa_pkg::*; import core_pkg::*; (
  input  wire word_t    pc,
  input  wire decoded_t dec,
  input  wire word_t    rs1_data,
  input  wire word_t    rs2_data,
  output exec_t         ex
);

  word_t              op_a;
  word_t              op_b;
  word_t              alu_res;
  word_t              pc_plus4;
  word_t              target_base;
  word_t              target_sum;
  word_t              target;
  logic [shamt_w-1:0] shamt;
  logic               taken;

  assign op_a  = dec.op_a_is_pc ? pc : rs1_data;
  assign op_b  = dec.op_b_is_imm ? dec.imm : rs2_data;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (dec.alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = op_a - op_b;
      alu_sll:    alu_res = op_a << shamt;
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_res = op_a ^ op_b;
      alu_srl:    alu_res = op_a >> shamt;
      alu_sra:    alu_res = $signed(op_a) >>> shamt;
      alu_or:     alu_res = op_a | op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    case (dec.branch_cond)
      br_never:  taken = 1'b0;
      br_always: taken = 1'b1;
      br_eq:     taken = (rs1_data == rs2_data);
      br_ne:     taken = (rs1_data != rs2_data);
      br_lt:     taken = ($signed(rs1_data) < $signed(rs2_data));
      br_ge:     taken = ($signed(rs1_data) >= $signed(rs2_data));
      br_ltu:    taken = (rs1_data < rs2_data);
      default:   taken = (rs1_data >= rs2_data);
    endcase
  end

  assign pc_plus4 = pc + 32'd4;

  // jalr: rs1 relative with bit 0 dropped
  assign target_base = dec.target_from_rs1 ? rs1_data : pc;
  assign target_sum  = target_base + dec.imm;
  assign target      = {target_sum[xlen-1:1], target_sum[0] & ~dec.target_from_rs1};

  assign ex = '{
    rd_data: dec.link ? pc_plus4 : alu_res,
    next_pc: taken ? target : pc_plus4,
    taken:   taken
  };

  always_comb begin
    if (pc[1:0] == 2'b00 && dec.imm[1:0] == 2'b00 &&
        (!dec.target_from_rs1 || rs1_data[1:0] == 2'b00)) begin
      assert (ex.next_pc[1:0] == 2'b00)
        else $error("misaligned next_pc %h from pc %h", ex.next_pc, pc);
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_isa_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire reg_idx_t rs1,
  input  wire reg_idx_t rs2,
  output word_t         rs1_data,
  output word_t         rs2_data,
  input  wire logic     we,
  input  wire reg_idx_t rd,
  input  wire word_t    rd_data
);

  localparam int num_regs = 2 ** reg_idx_w;

  // x0 has no storage
  word_t regs [1:num_regs-1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // commit filters rd == 0 before it reaches here
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> rd != '0)
    else $error("write requested to x0");

endmodule

`default_nettype wire

//--- logic/rv_commit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_commit import rv_isa_pkg::*; import core_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire word_t    insn,
  input  wire decoded_t dec,
  input  wire exec_t    ex,
  output word_t         pc,
  output logic          we,
  output reg_idx_t      rd,
  output word_t         rd_data,
  output logic          halt,
  output retire_t       retire
);

  logic commit;

  // nothing commits once halted
  assign commit  = !halt;
  assign we      = commit && dec.writes_rd && !dec.illegal && (dec.rd != '0);
  assign rd      = dec.rd;
  assign rd_data = ex.rd_data;

  always_ff @(posedge clk) begin
    // record payload, only meaningful while valid
    retire.pc      <= pc;
    retire.insn    <= insn;
    retire.rd      <= dec.rd;
    retire.we      <= we;
    retire.rd_data <= ex.rd_data;
    retire.illegal <= dec.illegal;
    retire.halt    <= dec.is_halt;

    if (rst) begin
      pc           <= reset_pc;
      halt         <= 1'b0;
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= commit;
      if (commit) begin
        // the ecall itself still moves pc on, then it freezes
        pc <= ex.next_pc;
        if (dec.is_halt) begin
          halt <= 1'b1;
        end
      end
    end
  end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else $error("halt dropped without reset");

  a_pc_frozen: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else $error("pc moved while halted");

  // fall-through means exactly one word ahead
  a_fall_through: assert property (@(posedge clk) disable iff (rst)
    !halt && !ex.taken |=> pc == $past(pc) + 32'd4)
    else $error("not-taken instruction did not advance pc by 4");

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_isa_pkg::*; import core_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  wire logic  clk,
  input  wire logic  rst,
  output word_t      pc,
  input  wire word_t insn,
  output logic       halt,
  output retire_t    retire
);

  decoded_t dec;
  exec_t    ex;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     rf_we;
  reg_idx_t rf_rd;
  word_t    rf_rd_data;

  rv_decode i_decode (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .rd_data  (rf_rd_data)
  );

  rv_execute i_execute (
    .pc       (pc),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex       (ex)
  );

  rv_commit #(
    .reset_pc (reset_pc)
  ) i_commit (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .dec     (dec),
    .ex      (ex),
    .pc      (pc),
    .we      (rf_we),
    .rd      (rf_rd),
    .rd_data (rf_rd_data),
    .halt    (halt),
    .retire  (retire)
  );

endmodule

`default_nettype wire

//--- sim/rv_iss_model.sv
`timescale 1ns/1ps
`default_nettype none

module rv_iss_model import rv_isa_pkg::*; import core_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire word_t insn,
  output word_t      pc,
  output logic       halt,
  output retire_t    ret
);

  word_t regs [32];

  // integer ops as the ISA manual defines them
  function automatic word_t alu(funct3_t f3, logic alt, word_t x, word_t y);
    word_t r;
    case (f3)
      f3_add_sub: r = alt ? x - y : x + y;
      f3_sll:     r = x << y[4:0];
      f3_slt:     r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      f3_sltu:    r = (x < y) ? 32'd1 : 32'd0;
      f3_xor:     r = x ^ y;
      f3_srl_sra: begin
        if (alt) begin
          r = $signed(x) >>> y[4:0];
        end else begin
          r = x >> y[4:0];
        end
      end
      f3_or:      r = x | y;
      default:    r = x & y;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(funct3_t f3, word_t x, word_t y);
    case (f3)
      f3_beq:  return x == y;
      f3_bne:  return x != y;
      f3_blt:  return $signed(x) < $signed(y);
      f3_bge:  return $signed(x) >= $signed(y);
      f3_bltu: return x < y;
      default: return x >= y;
    endcase
  endfunction

  always @(posedge clk) begin : step
    word_t    a;
    word_t    b;
    word_t    imm_i;
    word_t    res;
    word_t    nxt;
    funct3_t  f3;
    funct7_t  f7;
    reg_idx_t rd;
    logic     wr;
    logic     bad;
    logic     ecall;
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      pc   <= reset_pc;
      halt <= 1'b0;
      ret  <= '0;
    end else if (halt) begin
      ret.valid <= 1'b0;
    end else begin
      a     = regs[insn[19:15]];
      b     = regs[insn[24:20]];
      f3    = insn[14:12];
      f7    = insn[31:25];
      rd    = insn[11:7];
      imm_i = {{20{insn[31]}}, insn[31:20]};
      // link value by default, jumps keep it
      res   = pc + 32'd4;
      nxt   = pc + 32'd4;
      wr    = 1'b0;
      bad   = 1'b0;
      ecall = 1'b0;
      case (insn[6:0])
        op_lui: begin
          res = {insn[31:12], 12'h000};
          wr  = 1'b1;
        end
        op_auipc: begin
          res = pc + {insn[31:12], 12'h000};
          wr  = 1'b1;
        end
        op_jal: begin
          nxt = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
          wr  = 1'b1;
        end
        op_jalr: begin
          if (f3 != f3_jalr) begin
            bad = 1'b1;
          end else begin
            nxt = (a + imm_i) & ~32'd1;
            wr  = 1'b1;
          end
        end
        op_branch: begin
          if (f3 == 3'b010 || f3 == 3'b011) begin
            bad = 1'b1;
          end else if (branch_taken(f3, a, b)) begin
            nxt = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
          end
        end
        op_reg_imm: begin
          if ((f3 == f3_sll && f7 != f7_base) ||
              (f3 == f3_srl_sra && f7 != f7_base && f7 != f7_alt)) begin
            bad = 1'b1;
          end else begin
            res = alu(f3, f3 == f3_srl_sra && f7 == f7_alt, a, imm_i);
            wr  = 1'b1;
          end
        end
        op_reg_reg: begin
          if (f7 == f7_base || (f7 == f7_alt && (f3 == f3_add_sub || f3 == f3_srl_sra))) begin
            res = alu(f3, f7 == f7_alt, a, b);
            wr  = 1'b1;
          end else begin
            bad = 1'b1;
          end
        end
        op_system: begin
          if (insn == insn_ecall) begin
            ecall = 1'b1;
          end else begin
            bad = 1'b1;
          end
        end
        default: bad = 1'b1;
      endcase

      if (wr && rd != '0) begin
        regs[rd] <= res;
      end
      pc   <= nxt;
      halt <= ecall;
      ret  <= '{valid: 1'b1, pc: pc, insn: insn, rd: rd, we: wr && rd != '0,
                rd_data: res, illegal: bad, halt: ecall};
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_isa_pkg::*; import core_pkg::*; ();

  localparam word_t reset_pc       = 32'h0000_0000;
  localparam int    num_random     = 2000;
  localparam int    tail_cycles    = 10;
  localparam int    timeout_cycles = num_random + 50;
  localparam word_t insn_nop       = 32'h0000_0013;

  logic    clk;
  logic    rst;
  word_t   insn;
  word_t   pc;
  logic    halt;
  retire_t retire;
  word_t   exp_pc;
  logic    exp_halt;
  retire_t exp_ret;
  int      seed;
  int      cycles;
  logic    ecall_retired;

  rv_core i_dut (
    .clk    (clk),
    .rst    (rst),
    .pc     (pc),
    .insn   (insn),
    .halt   (halt),
    .retire (retire)
  );

  rv_iss_model #(
    .reset_pc (reset_pc)
  ) i_model (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .pc   (exp_pc),
    .halt (exp_halt),
    .ret  (exp_ret)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    $display("Fail %s: got %h, expected %h", name, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1, "mismatch on %s", name);
  endtask

  function automatic word_t random_insn();
    word_t       r;
    word_t       w;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    funct3_t     f3;
    logic [12:0] boff;
    logic [20:0] joff;
    r    = $random(seed);
    w    = $random(seed);
    // x0..x7 only, so results get read back often
    rd   = {2'b00, r[6:4]};
    rs1  = {2'b00, r[9:7]};
    rs2  = {2'b00, r[12:10]};
    f3   = r[15:13];
    // word aligned, -128 to +124 bytes
    boff = {{6{r[16]}}, r[21:17], 2'b00};
    joff = {{14{r[16]}}, r[21:17], 2'b00};
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: begin
        w[19:0] = {rs1, f3, rd, op_reg_imm};
        if (f3 == f3_sll) begin
          w[31:25] = f7_base;
        end
        if (f3 == f3_srl_sra) begin
          w[31:25] = r[22] ? f7_alt : f7_base;
        end
      end
      4'd4, 4'd5, 4'd6, 4'd7: begin
        w = {f7_base, rs2, rs1, f3, rd, op_reg_reg};
        if (r[22] && (f3 == f3_add_sub || f3 == f3_srl_sra)) begin
          w[31:25] = f7_alt;
        end
      end
      4'd8: w[11:0] = {rd, op_lui};
      4'd9: w[11:0] = {rd, op_auipc};
      4'd10, 4'd11: begin
        // 010 and 011 are not branches
        if (f3[2:1] == 2'b01) begin
          f3[2] = 1'b1;
        end
        w = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], op_branch};
      end
      4'd12: w = {joff[20], joff[10:1], joff[11], joff[19:12], rd, op_jal};
      4'd13: w = {{5{r[16]}}, r[21:17], 2'b00, rs1, f3_jalr, rd, op_jalr};
      default: begin
        case (r[24:23])
          2'd0: w[6:0] = 7'b0000011;
          2'd1: w = {7'b0000001, rs2, rs1, f3, rd, op_reg_reg};
          2'd2: w = 32'h0010_0073;
          default: w = {boff[12], boff[10:5], rs2, rs1, 3'b010, boff[4:1], boff[11], op_branch};
        endcase
      end
    endcase
    return w;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    abort_run($sformatf("core never halted within %0d cycles", timeout_cycles));
  end

  initial begin
    ecall_retired = 1'b0;
  end

  always @(posedge clk) begin
    if (!rst && retire.valid && retire.halt) begin
      ecall_retired <= 1'b1;
    end
  end

  initial begin
    seed = 32'hb29e_18a2;
    rst  = 1'b1;
    insn = insn_nop;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < num_random; n++) begin
      insn = random_insn();
      @(negedge clk);
    end
    insn = insn_ecall;
    @(negedge clk);
    while (!halt) begin
      insn = random_insn();
      @(negedge clk);
    end
    // halted core ignores whatever arrives
    repeat (tail_cycles) begin
      insn = random_insn();
      @(negedge clk);
    end
    if (ecall_retired && halt) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("ECALL never retired with halt set");
    end
  end

  // reset state holds through the first cycle after release
  a_reset_pc: assert property (@(posedge clk) rst |=> pc == reset_pc)
    else report_mismatch("pc", $sampled(pc), reset_pc);
  a_reset_halt: assert property (@(posedge clk) rst |=> !halt)
    else report_mismatch("halt", word_t'($sampled(halt)), '0);
  a_reset_valid: assert property (@(posedge clk) rst |=> !retire.valid)
    else report_mismatch("retire.valid", word_t'($sampled(retire.valid)), '0);

  a_pc: assert property (@(posedge clk) !rst |-> pc == exp_pc)
    else report_mismatch("pc", $sampled(pc), $sampled(exp_pc));
  a_halt: assert property (@(posedge clk) !rst |-> halt == exp_halt)
    else report_mismatch("halt", word_t'($sampled(halt)), word_t'($sampled(exp_halt)));
  a_valid: assert property (@(posedge clk) !rst |-> retire.valid == exp_ret.valid)
    else report_mismatch("retire.valid", word_t'($sampled(retire.valid)),
                         word_t'($sampled(exp_ret.valid)));

  a_ret_pc: assert property (@(posedge clk) !rst && exp_ret.valid |-> retire.pc == exp_ret.pc)
    else report_mismatch("retire.pc", $sampled(retire.pc), $sampled(exp_ret.pc));
  a_ret_insn: assert property (@(posedge clk)
    !rst && exp_ret.valid |-> retire.insn == exp_ret.insn)
    else report_mismatch("retire.insn", $sampled(retire.insn), $sampled(exp_ret.insn));
  a_ret_we: assert property (@(posedge clk) !rst && exp_ret.valid |-> retire.we == exp_ret.we)
    else report_mismatch("retire.we", word_t'($sampled(retire.we)),
                         word_t'($sampled(exp_ret.we)));
  a_ret_illegal: assert property (@(posedge clk)
    !rst && exp_ret.valid |-> retire.illegal == exp_ret.illegal)
    else report_mismatch("retire.illegal", word_t'($sampled(retire.illegal)),
                         word_t'($sampled(exp_ret.illegal)));
  a_ret_halt: assert property (@(posedge clk)
    !rst && exp_ret.valid |-> retire.halt == exp_ret.halt)
    else report_mismatch("retire.halt", word_t'($sampled(retire.halt)),
                         word_t'($sampled(exp_ret.halt)));

  // destination and data only matter on a write
  a_ret_rd: assert property (@(posedge clk)
    !rst && exp_ret.valid && exp_ret.we |-> retire.rd == exp_ret.rd)
    else report_mismatch("retire.rd", word_t'($sampled(retire.rd)),
                         word_t'($sampled(exp_ret.rd)));
  a_ret_data: assert property (@(posedge clk)
    !rst && exp_ret.valid && exp_ret.we |-> retire.rd_data == exp_ret.rd_data)
    else report_mismatch("retire.rd_data", $sampled(retire.rd_data),
                         $sampled(exp_ret.rd_data));

  a_illegal_no_write: assert property (@(posedge clk)
    !rst && exp_ret.valid && exp_ret.illegal |-> !retire.we)
    else report_mismatch("retire.we", word_t'($sampled(retire.we)), '0);
  a_illegal_next_pc: assert property (@(posedge clk)
    !rst && exp_ret.valid && exp_ret.illegal |-> pc == exp_ret.pc + 32'd4)
    else report_mismatch("pc", $sampled(pc), $sampled(exp_ret.pc) + 32'd4);

  a_halted_stays: assert property (@(posedge clk) !rst && halt |=> halt)
    else report_mismatch("halt", word_t'($sampled(halt)), 32'd1);
  a_halted_pc: assert property (@(posedge clk) !rst && halt |=> pc == $past(pc))
    else report_mismatch("pc", $sampled(pc), $past(pc));
  a_halted_quiet: assert property (@(posedge clk) !rst && halt |=> !retire.valid)
    else report_mismatch("retire.valid", word_t'($sampled(retire.valid)), '0);

endmodule

`default_nettype wire

//--- build.f
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_regfile.sv
logic/rv_commit.sv
logic/rv_core.sv
sim/rv_iss_model.sv
sim/tb_rv_core.sv

//--- Makefile
TOP := tb_rv_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), verdict from $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "test failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test failed, no verdict in $(LOG)"; exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
